/* compile.f */
verilog/video_pkg.sv
verilog/scan_axis.sv
verilog/capture_addr.sv
verilog/frame_buffer.sv
verilog/display_readout.sv
verilog/vga_scan_converter.sv
bench/tb_clock.sv
bench/tb_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top
RTL_TOP  = vga_scan_converter
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_top.sv */
`timescale 1ns/10ps

module tb_top import video_pkg::*; ();

    localparam int H_DISP    = 8;
    localparam int H_FRONT   = 2;
    localparam int H_PULSE   = 3;
    localparam int H_BACK    = 3;
    localparam int V_DISP    = 6;
    localparam int V_FRONT   = 1;
    localparam int V_PULSE   = 2;
    localparam int V_BACK    = 1;
    localparam int H_TOTAL   = H_DISP + H_FRONT + H_PULSE + H_BACK;
    localparam int V_TOTAL   = V_DISP + V_FRONT + V_PULSE + V_BACK;
    localparam int SCREEN    = H_TOTAL * V_TOTAL;
    localparam int LINE_STOP = 4;
    localparam int WR_START  = 496;
    localparam int WR_MAX    = 288;

    // test lengths in clock cycles, alignment to a screen start included
    localparam int RESET_LEN   = 8;
    localparam int CAPTURE_LEN = 64;
    localparam int CLIP_LEN    = 2 * WR_MAX + (512 - WR_MAX) * (H_DISP + 2);
    localparam int TEST_CYCLES = RESET_LEN + 2 * H_TOTAL + SCREEN + CAPTURE_LEN
                                 + 3 * SCREEN + CLIP_LEN + 2 * SCREEN;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic   CLK;
    logic   rst_n;
    logic   read_en;
    logic   write_en;
    logic   vsync;
    logic   hsync;
    pixel_t rgb;
    logic   vga_vsync;
    logic   vga_hsync;
    pixel_t vga_rgb;
    logic   vga_newline;
    logic   out_of_screen;

    int          rd_n = 0;
    int          edge_n = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'd32;
    pixel_t      ref_mem [0:3*LINE_WORDS-1];
    int          m_line = 0;
    int          m_col = 0;
    logic        m_hsync_q = 1'b0;

    tb_clock clock_i (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    vga_scan_converter #(
        .H_DISP         (11'd8),
        .H_FRONT        (11'd2),
        .H_PULSE        (11'd3),
        .H_BACK         (11'd3),
        .V_DISP         (10'd6),
        .V_FRONT        (10'd1),
        .V_PULSE        (10'd2),
        .V_BACK         (10'd1),
        .READ_COL_START (10'd0),
        .READ_LINE_STOP (10'd4)
    ) dut_i (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .read_en       (read_en),
        .write_en      (write_en),
        .vsync         (vsync),
        .hsync         (hsync),
        .rgb           (rgb),
        .vga_vsync     (vga_vsync),
        .vga_hsync     (vga_hsync),
        .vga_rgb       (vga_rgb),
        .vga_newline   (vga_newline),
        .out_of_screen (out_of_screen)
    );

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    // galois form, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    task automatic rand_pixel(output pixel_t p);
        p[0] = lfsr_bit();
        p[1] = lfsr_bit();
        p[2] = lfsr_bit();
    endtask

    // expected outputs after read_en edge n since reset
    function automatic int model_line(int n);
        int j;
        j = (n / H_TOTAL) % V_TOTAL;
        return (j < LINE_STOP) ? j : LINE_STOP;
    endfunction

    function automatic int model_hsync(int n);
        int p;
        p = n % H_TOTAL;
        return (p >= H_DISP + H_FRONT && p < H_DISP + H_FRONT + H_PULSE) ? 1 : 0;
    endfunction

    function automatic int model_vsync(int n);
        int j;
        j = (n / H_TOTAL) % V_TOTAL;
        return (j >= V_DISP + V_FRONT && j < V_DISP + V_FRONT + V_PULSE) ? 1 : 0;
    endfunction

    // -1 where the column sits past the visible part of a shown line
    function automatic int model_rgb(int n);
        int p;
        int line;
        int field;
        p = n % H_TOTAL;
        line = model_line(n);
        field = (n / SCREEN) % 2;
        if (line >= LINE_STOP || field != (line % 2))
            return 0;
        if (p >= H_DISP)
            return -1;
        return int'(ref_mem[(line / 2) * LINE_WORDS + p]);
    endfunction

    task automatic tick();
        @(posedge CLK);
        edge_n = rd_n;
        if (read_en)
            rd_n = rd_n + 1;
        #1;
    endtask

    task automatic check_value(string test, string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s %s expected %0d actual %0d", test, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "%s: wrong value on %s", test, what);
        end
    endtask

    task automatic check_outputs(string test, bit with_rgb);
        int exp_rgb;
        exp_rgb = model_rgb(edge_n);
        check_value(test, "vga_hsync", model_hsync(edge_n), int'(vga_hsync));
        check_value(test, "vga_vsync", model_vsync(edge_n), int'(vga_vsync));
        check_value(test, "vga_newline", (edge_n % H_TOTAL == H_TOTAL - 1) ? 1 : 0,
                    int'(vga_newline));
        check_value(test, "out_of_screen", (model_line(edge_n) >= LINE_STOP) ? 1 : 0,
                    int'(out_of_screen));
        if (with_rgb && exp_rgb >= 0)
            check_value(test, "vga_rgb", exp_rgb, int'(vga_rgb));
    endtask

    // one write_en cycle, mirrored into the reference buffer
    task automatic capture_cycle(logic vs, logic hs, pixel_t colour);
        logic fall;
        write_en = 1'b1;
        vsync = vs;
        hsync = hs;
        rgb = colour;
        if (m_line < 3)
            ref_mem[m_line * LINE_WORDS + m_col] = colour;
        fall = m_hsync_q & ~hs;
        if (vs) begin
            m_line = WR_START;
            m_col = 0;
        end else if (fall) begin
            m_col = 0;
            if (m_line != WR_MAX)
                m_line = (m_line + 1) % 512;
        end else if (m_col < int'(COL_LIMIT)) begin
            m_col = m_col + 1;
        end
        m_hsync_q = hs;
        tick();
    endtask

    task automatic write_line_pixels();
        pixel_t p;
        for (int k = 0; k < H_DISP; k++) begin
            rand_pixel(p);
            capture_cycle(1'b0, 1'b0, p);
        end
    endtask

    task automatic read_screens(string test, int screens);
        write_en = 1'b0;
        read_en = 1'b1;
        while (rd_n % SCREEN != 0) begin
            tick();
            check_outputs(test, 1'b1);
        end
        repeat (screens * SCREEN) begin
            tick();
            check_outputs(test, 1'b1);
        end
        read_en = 1'b0;
    endtask

    task automatic test_reset();
        check_value("reset", "vga_hsync", 0, int'(vga_hsync));
        check_value("reset", "vga_vsync", 0, int'(vga_vsync));
        check_value("reset", "vga_rgb", 0, int'(vga_rgb));
        check_value("reset", "vga_newline", 0, int'(vga_newline));
        check_value("reset", "out_of_screen", 0, int'(out_of_screen));
    endtask

    task automatic test_h_timing();
        int highs;
        int lines;
        highs = 0;
        lines = 0;
        read_en = 1'b1;
        repeat (2 * H_TOTAL) begin
            tick();
            check_outputs("h_timing", 1'b0);
            highs += int'(vga_hsync);
            lines += int'(vga_newline);
        end
        check_value("h_timing", "hsync cycles", 2 * H_PULSE, highs);
        check_value("h_timing", "newline pulses", 2, lines);
    endtask

    task automatic test_v_timing();
        int highs;
        highs = 0;
        repeat (SCREEN) begin
            tick();
            check_outputs("v_timing", 1'b0);
            highs += int'(vga_vsync);
        end
        check_value("v_timing", "vsync cycles", V_PULSE * H_TOTAL, highs);
        read_en = 1'b0;
    endtask

    // preload, then the 16th falling edge lands on buffer line 0
    task automatic test_capture_readout();
        capture_cycle(1'b1, 1'b1, 3'd0);
        for (int f = 1; f <= 18; f++) begin
            capture_cycle(1'b0, 1'b0, 3'd0);
            if (m_line < 3)
                write_line_pixels();
            capture_cycle(1'b0, 1'b1, 3'd0);
        end
        read_screens("capture_readout", 1);
    endtask

    task automatic test_field();
        read_screens("field", 1);
    endtask

    task automatic test_clipping();
        while (m_line != WR_MAX) begin
            capture_cycle(1'b0, 1'b0, 3'd0);
            capture_cycle(1'b0, 1'b1, 3'd0);
        end
        // line stays saturated, nothing may land in the buffer
        // enough lines to wrap back onto buffer line 0 if the line did not saturate
        repeat (512 - WR_MAX) begin
            capture_cycle(1'b0, 1'b0, 3'd0);
            write_line_pixels();
            capture_cycle(1'b0, 1'b1, 3'd0);
        end
        read_screens("clipping", 1);
    endtask

    initial begin
        read_en = 1'b0;
        write_en = 1'b0;
        vsync = 1'b0;
        hsync = 1'b0;
        rgb = 3'd0;
        wait (rst_n === 1'b1);
        test_reset();
        test_h_timing();
        test_v_timing();
        test_capture_readout();
        test_field();
        test_clipping();
        $display("** PASS **");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic CLK,
    output logic rst_n
);

    // 100 ns period
    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // reset held over the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge CLK);
        #1 rst_n = 1'b1;
    end

endmodule

/* verilog/vga_scan_converter.sv */
`timescale 1ns/10ps

module vga_scan_converter import video_pkg::*; #(
    parameter hcount_t     H_DISP           = 11'd640,
    parameter hcount_t     H_FRONT          = 11'd16,
    parameter hcount_t     H_PULSE          = 11'd96,
    parameter hcount_t     H_BACK           = 11'd48,
    parameter vcount_t     V_DISP           = 10'd480,
    parameter vcount_t     V_FRONT          = 10'd10,
    parameter vcount_t     V_PULSE          = 10'd2,
    parameter vcount_t     V_BACK           = 10'd33,
    parameter read_col_t   READ_COL_START   = 10'd100,
    parameter read_line_t  READ_LINE_STOP   = 10'd576,
    parameter write_line_t WRITE_LINE_START = 9'h1F0,
    parameter write_line_t WRITE_LINE_MAX   = 9'd288
) (
    input  logic   CLK,
    input  logic   rst_n,
    input  logic   read_en,
    input  logic   write_en,
    input  logic   vsync,
    input  logic   hsync,
    input  pixel_t rgb,
    output logic   vga_vsync,
    output logic   vga_hsync,
    output pixel_t vga_rgb,
    output logic   vga_newline,
    output logic   out_of_screen
);

    scan_phase_t h_phase;
    scan_phase_t v_phase;
    logic        h_wrap;
    logic        v_wrap;
    logic        v_step;
    logic        new_screen;
    buf_addr_t   wr_addr;
    logic        wr_allow;
    buf_addr_t   rd_addr;
    pixel_t      rd_pixel;

    // vertical axis advances once per line
    assign v_step     = h_wrap & read_en;
    assign new_screen = h_wrap & v_wrap;

    scan_axis #(
        .DISP  (H_DISP),
        .FRONT (H_FRONT),
        .PULSE (H_PULSE),
        .BACK  (H_BACK)
    ) h_axis (
        .CLK   (CLK),
        .rst_n (rst_n),
        .step  (read_en),
        .phase (h_phase),
        .wrap  (h_wrap)
    );

    scan_axis #(
        .DISP  (hcount_t'(V_DISP)),
        .FRONT (hcount_t'(V_FRONT)),
        .PULSE (hcount_t'(V_PULSE)),
        .BACK  (hcount_t'(V_BACK))
    ) v_axis (
        .CLK   (CLK),
        .rst_n (rst_n),
        .step  (v_step),
        .phase (v_phase),
        .wrap  (v_wrap)
    );

    capture_addr #(
        .WRITE_LINE_START (WRITE_LINE_START),
        .WRITE_LINE_MAX   (WRITE_LINE_MAX)
    ) capture_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .write_en (write_en),
        .hsync    (hsync),
        .vsync    (vsync),
        .wr_addr  (wr_addr),
        .wr_allow (wr_allow)
    );

    frame_buffer buffer_i (
        .CLK      (CLK),
        .write_en (write_en),
        .wr_addr  (wr_addr),
        .wr_allow (wr_allow),
        .rgb      (rgb),
        .read_en  (read_en),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

    display_readout #(
        .READ_COL_START (READ_COL_START),
        .READ_LINE_STOP (READ_LINE_STOP)
    ) readout_i (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .read_en       (read_en),
        .h_phase       (h_phase),
        .v_phase       (v_phase),
        .new_line      (h_wrap),
        .new_screen    (new_screen),
        .rd_addr       (rd_addr),
        .rd_pixel      (rd_pixel),
        .vga_hsync     (vga_hsync),
        .vga_vsync     (vga_vsync),
        .vga_rgb       (vga_rgb),
        .vga_newline   (vga_newline),
        .out_of_screen (out_of_screen)
    );

endmodule

/* verilog/display_readout.sv */
`timescale 1ns/10ps

module display_readout import video_pkg::*; #(
    parameter read_col_t  READ_COL_START = 10'd100,
    parameter read_line_t READ_LINE_STOP = 10'd576
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        read_en,
    input  scan_phase_t h_phase,
    input  scan_phase_t v_phase,
    input  logic        new_line,
    input  logic        new_screen,
    output buf_addr_t   rd_addr,
    input  pixel_t      rd_pixel,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output pixel_t      vga_rgb,
    output logic        vga_newline,
    output logic        out_of_screen
);

    read_line_t line;
    read_col_t  col;
    logic       field;
    logic       line_stop;
    logic       col_full;
    logic       disp_en;
    logic       blank;
    logic       blank_q;

    assign line_stop = (line >= READ_LINE_STOP);
    assign col_full  = (col >= COL_LIMIT);
    assign disp_en   = (h_phase == PH_DISP) && (v_phase == PH_DISP);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            line  <= '0;
            col   <= READ_COL_START;
            field <= 1'b0;
        end else if (read_en) begin
            if (new_screen) begin
                line  <= '0;
                col   <= READ_COL_START;
                field <= ~field;
            end else if (new_line) begin
                col <= READ_COL_START;
                if (!line_stop)
                    line <= line + 10'd1;
            end else if (disp_en && !col_full) begin
                col <= col + 10'd1;
            end
        end
    end

    // each stored line serves two VGA lines
    assign rd_addr = {line[9:1], col};

    // only lines whose low bit matches the field show the buffer
    assign blank = col_full | line_stop | (field ^ line[0]);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            blank_q       <= 1'b1;
            vga_hsync     <= 1'b0;
            vga_vsync     <= 1'b0;
            vga_newline   <= 1'b0;
            out_of_screen <= 1'b0;
        end else if (read_en) begin
            blank_q       <= blank;
            vga_hsync     <= (h_phase == PH_PULSE);
            vga_vsync     <= (v_phase == PH_PULSE);
            vga_newline   <= new_line;
            out_of_screen <= line_stop;
        end
    end

    // rd_pixel and blank_q come from the same read_en edge
    assign vga_rgb = blank_q ? 3'b000 : rd_pixel;

endmodule

/* verilog/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer import video_pkg::*; (
    input  logic      CLK,
    input  logic      write_en,
    input  buf_addr_t wr_addr,
    input  logic      wr_allow,
    input  pixel_t    rgb,
    input  logic      read_en,
    input  buf_addr_t rd_addr,
    output pixel_t    rd_pixel
);

    pixel_t    mem [BUF_DEPTH];

    buf_addr_t wr_addr_q;
    pixel_t    rgb_q;
    logic      wr_allow_q;

    // one stage of write pipeline, stored on the following write_en
    always_ff @(posedge CLK) begin
        if (write_en) begin
            wr_addr_q  <= wr_addr;
            rgb_q      <= rgb;
            wr_allow_q <= wr_allow;
            if (wr_allow_q)
                mem[wr_addr_q] <= rgb_q;
        end
    end

    // read port at the VGA pixel rate
    always_ff @(posedge CLK) begin
        if (read_en) begin
            rd_pixel <= mem[rd_addr];
        end
    end

endmodule

/* verilog/capture_addr.sv */
`timescale 1ns/10ps

module capture_addr import video_pkg::*; #(
    parameter write_line_t WRITE_LINE_START = 9'h1F0,
    parameter write_line_t WRITE_LINE_MAX   = 9'd288
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      write_en,
    input  logic      hsync,
    input  logic      vsync,
    output buf_addr_t wr_addr,
    output logic      wr_allow
);

    write_line_t line;
    write_col_t  col;
    logic        hsync_q;
    logic        hsync_fall;
    logic        col_full;

    // hsync sampled at the capture pixel rate
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            hsync_q <= 1'b0;
        end else if (write_en) begin
            hsync_q <= hsync;
        end
    end

    assign hsync_fall = hsync_q & ~hsync;
    assign col_full   = (col >= COL_LIMIT);

    // preload sits above 288 and wraps through 511 to 0, skipping the top lines
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            line <= '0;
            col  <= '0;
        end else if (write_en) begin
            if (vsync) begin
                line <= WRITE_LINE_START;
                col  <= '0;
            end else if (hsync_fall) begin
                col <= '0;
                if (line != WRITE_LINE_MAX)
                    line <= line + 9'd1;
            end else if (!col_full) begin
                col <= col + 10'd1;
            end
        end
    end

    assign wr_addr = {line, col};

    // lines at or past the limit never reach the buffer
    assign wr_allow = (line < WRITE_LINE_MAX);

endmodule

/* verilog/scan_axis.sv */
`timescale 1ns/10ps

module scan_axis import video_pkg::*; #(
    parameter hcount_t DISP  = 11'd640,
    parameter hcount_t FRONT = 11'd16,
    parameter hcount_t PULSE = 11'd96,
    parameter hcount_t BACK  = 11'd48
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        step,
    output scan_phase_t phase,
    output logic        wrap
);

    // counter runs TOP down to 0, one phase after another
    localparam hcount_t TOP       = hcount_t'(DISP + FRONT + PULSE + BACK - 11'd1);
    localparam hcount_t END_DISP  = hcount_t'(FRONT + PULSE + BACK);
    localparam hcount_t END_FRONT = hcount_t'(PULSE + BACK);
    localparam hcount_t END_PULSE = BACK;

    hcount_t count;

    assign wrap = (count == '0);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            count <= TOP;
        end else if (step) begin
            if (wrap) begin
                count <= TOP;
            end else begin
                count <= count - 11'd1;
            end
        end
    end

    // phase moves on at the last count of the current phase
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_DISP;
        end else if (step) begin
            case (phase)
                PH_DISP: begin
                    if (count == END_DISP)
                        phase <= PH_FRONT;
                end
                PH_FRONT: begin
                    if (count == END_FRONT)
                        phase <= PH_PULSE;
                end
                PH_PULSE: begin
                    if (count == END_PULSE)
                        phase <= PH_BACK;
                end
                PH_BACK: begin
                    if (wrap)
                        phase <= PH_DISP;
                end
                default: begin
                    phase <= PH_DISP;
                end
            endcase
        end
    end

endmodule

/* verilog/video_pkg.sv */
package video_pkg;

    // buffer geometry: one line holds 1024 columns, lines 0..287 are stored
    localparam int BUF_ADDR_W  = 19;
    localparam int LINE_WORDS  = 1024;
    localparam int BUF_LINES   = 288;
    localparam int BUF_DEPTH   = BUF_LINES * LINE_WORDS;

    // one bit per primary
    typedef logic [2:0]            pixel_t;

    // timing counters and phase lengths
    typedef logic [10:0]           hcount_t;
    typedef logic [9:0]            vcount_t;

    // read side position
    typedef logic [9:0]            read_col_t;
    typedef logic [9:0]            read_line_t;

    // write side position
    typedef logic [9:0]            write_col_t;
    typedef logic [8:0]            write_line_t;

    // source line in the upper bits, column in the lower ten
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // shared by both timing axes
    typedef enum logic [1:0] {
        PH_DISP  = 2'd0,
        PH_FRONT = 2'd1,
        PH_PULSE = 2'd2,
        PH_BACK  = 2'd3
    } scan_phase_t;

    // top three column bits all set
    localparam logic [9:0] COL_LIMIT = 10'd896;

endpackage
